//--- design/cache_perf_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module cache_perf_monitor import perf_pkg::*; #(
	parameter int JCNT = 100
) (
	input  logic             clk,
	input  logic             rstn,
	input  logic             read_c_l1i,
	input  logic             miss_l1i_c,
	input  logic             read_c_l1d,
	input  logic             write_c_l1d,
	input  logic             miss_l1d_c,
	input  logic             read_l1_l2,
	input  logic             write_l1_l2,
	input  logic             miss_l2_l1,
	output logic [CNT_W-1:0] data_o
);

	logic [CNT_W-1:0] cnt_l1i_read;
	logic [CNT_W-1:0] cnt_l1i_miss;
	logic [CNT_W-1:0] cnt_l1d_read;
	logic [CNT_W-1:0] cnt_l1d_write;
	logic [CNT_W-1:0] cnt_l1d_miss;
	logic [CNT_W-1:0] cnt_l2_read;
	logic [CNT_W-1:0] cnt_l2_write;
	logic [CNT_W-1:0] cnt_l2_miss;

	l1_event_tally l1_event_tally_inst (
		.clk          (clk),
		.rstn         (rstn),
		.read_c_l1i   (read_c_l1i),
		.miss_l1i_c   (miss_l1i_c),
		.read_c_l1d   (read_c_l1d),
		.write_c_l1d  (write_c_l1d),
		.miss_l1d_c   (miss_l1d_c),
		.cnt_l1i_read (cnt_l1i_read),
		.cnt_l1i_miss (cnt_l1i_miss),
		.cnt_l1d_read (cnt_l1d_read),
		.cnt_l1d_write(cnt_l1d_write),
		.cnt_l1d_miss (cnt_l1d_miss)
	);

	l2_event_tally l2_event_tally_inst (
		.clk         (clk),
		.rstn        (rstn),
		.read_l1_l2  (read_l1_l2),
		.write_l1_l2 (write_l1_l2),
		.miss_l2_l1  (miss_l2_l1),
		.cnt_l2_read (cnt_l2_read),
		.cnt_l2_write(cnt_l2_write),
		.cnt_l2_miss (cnt_l2_miss)
	);

	// Both banks feed one sequencer that interleaves their results on data_o
	report_sequencer #(
		.JCNT(JCNT)
	) report_sequencer_inst (
		.clk          (clk),
		.rstn         (rstn),
		.cnt_l1i_read (cnt_l1i_read),
		.cnt_l1i_miss (cnt_l1i_miss),
		.cnt_l1d_read (cnt_l1d_read),
		.cnt_l1d_write(cnt_l1d_write),
		.cnt_l1d_miss (cnt_l1d_miss),
		.cnt_l2_read  (cnt_l2_read),
		.cnt_l2_write (cnt_l2_write),
		.cnt_l2_miss  (cnt_l2_miss),
		.data_o       (data_o)
	);

endmodule

`default_nettype wire

//--- design/l1_event_tally.sv
`timescale 1ns/1ns
`default_nettype none

module l1_event_tally import perf_pkg::*; (
	input  logic             clk,
	input  logic             rstn,
	input  logic             read_c_l1i,
	input  logic             miss_l1i_c,
	input  logic             read_c_l1d,
	input  logic             write_c_l1d,
	input  logic             miss_l1d_c,
	output logic [CNT_W-1:0] cnt_l1i_read,
	output logic [CNT_W-1:0] cnt_l1i_miss,
	output logic [CNT_W-1:0] cnt_l1d_read,
	output logic [CNT_W-1:0] cnt_l1d_write,
	output logic [CNT_W-1:0] cnt_l1d_miss
);

	localparam int NUM_EV = 5;

	// Bit positions of the L1 strobes inside the packed vectors
	localparam int EV_L1I_READ  = 0;
	localparam int EV_L1I_MISS  = 1;
	localparam int EV_L1D_READ  = 2;
	localparam int EV_L1D_WRITE = 3;
	localparam int EV_L1D_MISS  = 4;

	logic [NUM_EV-1:0] strobe;
	logic [NUM_EV-1:0] strobe_prev;
	logic [NUM_EV-1:0] rise;
	logic [CNT_W-1:0]  cnt [NUM_EV];

	assign strobe[EV_L1I_READ]  = read_c_l1i;
	assign strobe[EV_L1I_MISS]  = miss_l1i_c;
	assign strobe[EV_L1D_READ]  = read_c_l1d;
	assign strobe[EV_L1D_WRITE] = write_c_l1d;
	assign strobe[EV_L1D_MISS]  = miss_l1d_c;

	// An event is a 0 to 1 step of its strobe between two samples
	assign rise = strobe & ~strobe_prev;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			strobe_prev <= '0;
		end else begin
			strobe_prev <= strobe;
		end
	end

	for (genvar i = 0; i < NUM_EV; i++) begin : g_cnt
		always_ff @(posedge clk) begin
			if (!rstn) begin
				cnt[i] <= '0;
			end else if (rise[i]) begin
				cnt[i] <= cnt[i] + 1'b1; // Free running and wraps at 256
			end
		end

		// A counter moves by one at most and only after its strobe input was high
		a_cnt_step: assert property (
			@(posedge clk) disable iff (!rstn)
			$past(rstn) |->
				(cnt[i] == $past(cnt[i])) ||
				((cnt[i] == CNT_W'($past(cnt[i]) + 1'b1)) && $past(strobe[i]))
		);
	end

	assign cnt_l1i_read  = cnt[EV_L1I_READ];
	assign cnt_l1i_miss  = cnt[EV_L1I_MISS];
	assign cnt_l1d_read  = cnt[EV_L1D_READ];
	assign cnt_l1d_write = cnt[EV_L1D_WRITE];
	assign cnt_l1d_miss  = cnt[EV_L1D_MISS];

endmodule

`default_nettype wire

//--- design/l2_event_tally.sv
`timescale 1ns/1ns
`default_nettype none

module l2_event_tally import perf_pkg::*; (
	input  logic             clk,
	input  logic             rstn,
	input  logic             read_l1_l2,
	input  logic             write_l1_l2,
	input  logic             miss_l2_l1,
	output logic [CNT_W-1:0] cnt_l2_read,
	output logic [CNT_W-1:0] cnt_l2_write,
	output logic [CNT_W-1:0] cnt_l2_miss
);

	localparam int NUM_EV = 3;

	localparam int EV_L2_READ  = 0;
	localparam int EV_L2_WRITE = 1;
	localparam int EV_L2_MISS  = 2;

	logic [NUM_EV-1:0] strobe;
	logic [NUM_EV-1:0] strobe_prev;
	logic [NUM_EV-1:0] rise;
	logic [CNT_W-1:0]  cnt [NUM_EV];

	assign strobe[EV_L2_READ]  = read_l1_l2;
	assign strobe[EV_L2_WRITE] = write_l1_l2;
	assign strobe[EV_L2_MISS]  = miss_l2_l1;

	assign rise = strobe & ~strobe_prev; // Held high counts once

	always_ff @(posedge clk) begin
		if (!rstn) begin
			strobe_prev <= '0;
		end else begin
			strobe_prev <= strobe;
		end
	end

	for (genvar i = 0; i < NUM_EV; i++) begin : g_cnt
		always_ff @(posedge clk) begin
			if (!rstn) begin
				cnt[i] <= '0;
			end else if (rise[i]) begin
				cnt[i] <= cnt[i] + 1'b1;
			end
		end

		// No 0 to 1 step seen on the strobe input means the count is unchanged next cycle
		a_cnt_hold: assert property (
			@(posedge clk) disable iff (!rstn)
			$past(rstn) && !(strobe[i] && !$past(strobe[i])) |=> $stable(cnt[i])
		);
	end

	assign cnt_l2_read  = cnt[EV_L2_READ];
	assign cnt_l2_write = cnt[EV_L2_WRITE];
	assign cnt_l2_miss  = cnt[EV_L2_MISS];

endmodule

`default_nettype wire

//--- design/perf_pkg.sv
`default_nettype none

package perf_pkg;

	// Width of every event counter and of the report byte
	localparam int CNT_W = 8;

	localparam int NUM_SLOTS = 6; // Results shown per report period

	// Report order on data_o, one slot every JCNT cycles
	typedef enum logic [2:0] {
		SLOT_L1I_MISS   = 3'd0,
		SLOT_L1I_READ   = 3'd1,
		SLOT_L1D_MISS   = 3'd2,
		SLOT_L1D_ACCESS = 3'd3, // L1D reads plus writes
		SLOT_L2_MISS    = 3'd4,
		SLOT_L2_ACCESS  = 3'd5  // L2 reads plus writes
	} report_slot_t;

	// Slot that follows the given one, wrapping after the L2 access slot
	function automatic report_slot_t next_slot(input report_slot_t slot);
		report_slot_t nxt;
		case (slot)
			SLOT_L1I_MISS:   nxt = SLOT_L1I_READ;
			SLOT_L1I_READ:   nxt = SLOT_L1D_MISS;
			SLOT_L1D_MISS:   nxt = SLOT_L1D_ACCESS;
			SLOT_L1D_ACCESS: nxt = SLOT_L2_MISS;
			SLOT_L2_MISS:    nxt = SLOT_L2_ACCESS;
			default:         nxt = SLOT_L1I_MISS;
		endcase
		return nxt;
	endfunction

endpackage

`default_nettype wire

//--- design/report_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module report_sequencer import perf_pkg::*; #(
	parameter int JCNT = 100
) (
	input  logic             clk,
	input  logic             rstn,
	input  logic [CNT_W-1:0] cnt_l1i_read,
	input  logic [CNT_W-1:0] cnt_l1i_miss,
	input  logic [CNT_W-1:0] cnt_l1d_read,
	input  logic [CNT_W-1:0] cnt_l1d_write,
	input  logic [CNT_W-1:0] cnt_l1d_miss,
	input  logic [CNT_W-1:0] cnt_l2_read,
	input  logic [CNT_W-1:0] cnt_l2_write,
	input  logic [CNT_W-1:0] cnt_l2_miss,
	output logic [CNT_W-1:0] data_o
);

	// The timer counts 0 to TIMER_MAX inclusive so one period is TIMER_MAX + 1 cycles
	localparam int TIMER_MAX = NUM_SLOTS * JCNT;
	localparam int TIMER_W   = $clog2(TIMER_MAX + 1);

	logic [TIMER_W-1:0] timer;
	logic [TIMER_W-1:0] slot_mark;
	logic               at_boundary;
	report_slot_t       slot;

	logic [CNT_W-1:0] snap_l1i_read;
	logic [CNT_W-1:0] snap_l1i_miss;
	logic [CNT_W-1:0] snap_l1d_read;
	logic [CNT_W-1:0] snap_l1d_write;
	logic [CNT_W-1:0] snap_l1d_miss;
	logic [CNT_W-1:0] snap_l2_read;
	logic [CNT_W-1:0] snap_l2_write;
	logic [CNT_W-1:0] snap_l2_miss;

	logic [CNT_W-1:0] l1d_access;
	logic [CNT_W-1:0] l2_access;
	logic [CNT_W-1:0] slot_value;

	// Slot k is shown on the edge where the timer reaches (k + 1) * JCNT
	assign slot_mark   = TIMER_W'((int'(slot) + 1) * JCNT);
	assign at_boundary = (timer == slot_mark);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			timer  <= '0;
			slot   <= SLOT_L1I_MISS;
			data_o <= '0;
		end else begin
			if (timer == TIMER_W'(TIMER_MAX)) begin
				timer <= '0;
			end else begin
				timer <= timer + 1'b1;
			end
			if (at_boundary) begin
				data_o <= slot_value;
				slot   <= next_slot(slot); // Wraps back to the L1I miss slot
			end
		end
	end

	// All eight counts are frozen together so one report is self consistent
	always_ff @(posedge clk) begin
		if (timer == '0) begin
			snap_l1i_read  <= cnt_l1i_read;
			snap_l1i_miss  <= cnt_l1i_miss;
			snap_l1d_read  <= cnt_l1d_read;
			snap_l1d_write <= cnt_l1d_write;
			snap_l1d_miss  <= cnt_l1d_miss;
			snap_l2_read   <= cnt_l2_read;
			snap_l2_write  <= cnt_l2_write;
			snap_l2_miss   <= cnt_l2_miss;
		end
	end

	assign l1d_access = snap_l1d_read + snap_l1d_write; // Modulo 256
	assign l2_access  = snap_l2_read + snap_l2_write;

	always_comb begin
		case (slot)
			SLOT_L1I_MISS:   slot_value = snap_l1i_miss;
			SLOT_L1I_READ:   slot_value = snap_l1i_read;
			SLOT_L1D_MISS:   slot_value = snap_l1d_miss;
			SLOT_L1D_ACCESS: slot_value = l1d_access;
			SLOT_L2_MISS:    slot_value = snap_l2_miss;
			SLOT_L2_ACCESS:  slot_value = l2_access;
			default:         slot_value = '0;
		endcase
	end

	a_timer_range: assert property (
		@(posedge clk) disable iff (!rstn)
		timer <= TIMER_W'(TIMER_MAX)
	);

	// The output byte only moves on an edge where the timer sat on a nonzero multiple of JCNT
	a_data_hold: assert property (
		@(posedge clk) disable iff (!rstn)
		$past(rstn) && $changed(data_o) |->
			($past(timer) != '0) && (($past(timer) % JCNT) == 0)
	);

endmodule

`default_nettype wire

//--- src.f
design/perf_pkg.sv
design/l1_event_tally.sv
design/l2_event_tally.sv
design/report_sequencer.sv
design/cache_perf_monitor.sv
verif/perf_checker.sv
verif/cache_perf_monitor_tb.sv

//--- verif/cache_perf_monitor_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cache_perf_monitor_tb import perf_pkg::*; ();

	localparam int JCNT      = 4;
	localparam int PERIOD    = NUM_SLOTS * JCNT + 1; // Cycles per report period
	localparam int MAX_REC   = 64;
	localparam int DRIVE_DLY = 10;

	logic             clk;
	logic             rstn;
	logic             read_c_l1i;
	logic             miss_l1i_c;
	logic             read_c_l1d;
	logic             write_c_l1d;
	logic             miss_l1d_c;
	logic             read_l1_l2;
	logic             write_l1_l2;
	logic             miss_l2_l1;
	logic [CNT_W-1:0] data_o;

	int               test_id       = 0;
	logic             run_end       = 1'b0;
	int               mismatches;
	int               tests_passed;
	int               tests_failed;
	int               cycle_count   = 0;
	int               timeout_limit = 0;
	logic [31:0]      lcg_state     = 32'd28;
	logic [31:0]      records [MAX_REC]; // Hex digits T M KK HHHH per record

	cache_perf_monitor #(
		.JCNT(JCNT)
	) cache_perf_monitor_inst (
		.clk        (clk),
		.rstn       (rstn),
		.read_c_l1i (read_c_l1i),
		.miss_l1i_c (miss_l1i_c),
		.read_c_l1d (read_c_l1d),
		.write_c_l1d(write_c_l1d),
		.miss_l1d_c (miss_l1d_c),
		.read_l1_l2 (read_l1_l2),
		.write_l1_l2(write_l1_l2),
		.miss_l2_l1 (miss_l2_l1),
		.data_o     (data_o)
	);

	perf_checker #(
		.JCNT(JCNT)
	) perf_checker_inst (
		.clk         (clk),
		.rstn        (rstn),
		.read_c_l1i  (read_c_l1i),
		.miss_l1i_c  (miss_l1i_c),
		.read_c_l1d  (read_c_l1d),
		.write_c_l1d (write_c_l1d),
		.miss_l1d_c  (miss_l1d_c),
		.read_l1_l2  (read_l1_l2),
		.write_l1_l2 (write_l1_l2),
		.miss_l2_l1  (miss_l2_l1),
		.data_o      (data_o),
		.test_id     (test_id),
		.run_end     (run_end),
		.mismatches  (mismatches),
		.tests_passed(tests_passed),
		.tests_failed(tests_failed)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic apply_events(input logic [7:0] mask);
		read_c_l1i  = mask[0];
		miss_l1i_c  = mask[1];
		read_c_l1d  = mask[2];
		write_c_l1d = mask[3];
		miss_l1d_c  = mask[4];
		read_l1_l2  = mask[5];
		write_l1_l2 = mask[6];
		miss_l2_l1  = mask[7];
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			$display("Timeout: the run did not end within %0d cycles", timeout_limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin : stimulus
		int         n_rec;
		int         total_hold;
		int         hold;
		logic [3:0] mode;
		logic [7:0] mask;
		rstn = 1'b0;
		apply_events(8'h00);
		$readmemh("verif/cache_perf_testdata.txt", records);
		n_rec      = 0;
		total_hold = 0;
		while (n_rec < MAX_REC && !$isunknown(records[n_rec])) begin
			total_hold += records[n_rec][15:0];
			n_rec++;
		end
		timeout_limit = total_hold + 2 * PERIOD;
		repeat (2) @(posedge clk);
		#DRIVE_DLY;
		rstn = 1'b1;
		for (int i = 0; i < n_rec; i++) begin
			mode = records[i][27:24];
			mask = records[i][23:16];
			hold = records[i][15:0];
			for (int c = 0; c < hold; c++) begin
				@(posedge clk);
				#DRIVE_DLY;
				test_id = records[i][31:28];
				case (mode)
					4'd1: apply_events((c % 2 == 0) ? mask : 8'h00); // Rises every second cycle
					4'd2: begin
						lcg_state = lcg_next(lcg_state);
						apply_events(lcg_state[23:16] & mask);
					end
					default: apply_events(mask);
				endcase
			end
		end
		@(posedge clk);
		#DRIVE_DLY;
		apply_events(8'h00);
		// The last snapshot needs one whole period to reach data_o
		repeat (PERIOD + 2) @(posedge clk);
		run_end = 1'b1;
		repeat (2) @(posedge clk);
		if (mismatches == 0 && tests_failed == 0 && tests_passed > 0) begin
			$display("Result: PASSED");
		end else begin
			if (tests_passed + tests_failed == 0) begin
				$display("No test records were read from the data file");
			end
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/cache_perf_testdata.txt
// One record per line as eight hex digits T M KK HHHH
// T test number, M mode (0 hold, 1 toggle every cycle, 2 LCG masks), KK event mask, HHHH cycles
// Mask bits 0 to 7: l1i read, l1i miss, l1d read, l1d write, l1d miss, l2 read, l2 write, l2 miss

// Test 1: nothing rises after reset, the first reports are all zero
1000003C

// Test 2: strobes held high for many cycles count once each
20810050
2000003C
20100028
2000003C

// Test 3: l1d miss and l2 read toggle across more than one period
3130001E
3000003C

// Test 4: reads and writes with different counts for the access sums
414C0014
4124000E
4000003C

// Test 5: 300 rising edges on every strobe wrap the counts and sums
51FF0258
5000003C

// Test 6: LCG masks on all eight strobes for four periods
62FF0064
6000003C

//--- verif/perf_checker.sv
`timescale 1ns/1ns
`default_nettype none

module perf_checker import perf_pkg::*; #(
	parameter int JCNT = 100
) (
	input  logic             clk,
	input  logic             rstn,
	input  logic             read_c_l1i,
	input  logic             miss_l1i_c,
	input  logic             read_c_l1d,
	input  logic             write_c_l1d,
	input  logic             miss_l1d_c,
	input  logic             read_l1_l2,
	input  logic             write_l1_l2,
	input  logic             miss_l2_l1,
	input  logic [CNT_W-1:0] data_o,
	input  int               test_id,
	input  logic             run_end,
	output int               mismatches,
	output int               tests_passed,
	output int               tests_failed
);

	localparam int TIMER_MAX = NUM_SLOTS * JCNT;

	// Same bit order as the event mask in the test data
	logic [7:0]       strobe;
	logic [7:0]       prev;
	logic [CNT_W-1:0] cnt [8];
	logic [CNT_W-1:0] snap [8];
	int               timer;
	logic [CNT_W-1:0] exp_data;
	report_slot_t     exp_slot;
	int               cur_test    = 0;
	int               test_errors = 0;
	int               total_errors = 0;
	int               n_pass = 0;
	int               n_fail = 0;
	logic             closed = 1'b0;

	assign strobe = {miss_l2_l1, write_l1_l2, read_l1_l2, miss_l1d_c,
		write_c_l1d, read_c_l1d, miss_l1i_c, read_c_l1i};

	assign mismatches   = total_errors;
	assign tests_passed = n_pass;
	assign tests_failed = n_fail;

	function automatic logic [CNT_W-1:0] expected_slot(input report_slot_t slot);
		case (slot)
			SLOT_L1I_MISS:   return snap[1];
			SLOT_L1I_READ:   return snap[0];
			SLOT_L1D_MISS:   return snap[4];
			SLOT_L1D_ACCESS: return snap[2] + snap[3]; // Truncated to 8 bits, so it wraps
			SLOT_L2_MISS:    return snap[7];
			SLOT_L2_ACCESS:  return snap[5] + snap[6];
			default:         return '0;
		endcase
	endfunction

	always @(posedge clk) begin
		if (!rstn) begin
			prev     <= '0;
			timer    <= 0;
			exp_data <= '0;
			for (int i = 0; i < 8; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			prev <= strobe;
			for (int i = 0; i < 8; i++) begin
				if (strobe[i] && !prev[i]) begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
			timer <= (timer == TIMER_MAX) ? 0 : timer + 1;
			if (timer == 0) begin
				for (int i = 0; i < 8; i++) begin
					snap[i] <= cnt[i]; // Counts as they stood before this edge
				end
			end else if (timer % JCNT == 0) begin
				exp_slot <= report_slot_t'(timer / JCNT - 1);
				exp_data <= expected_slot(report_slot_t'(timer / JCNT - 1));
			end
		end
	end

	// Compare at the falling edge where both sides are settled
	always @(negedge clk) begin
		if (data_o !== exp_data) begin
			$display("Fail at %0t ns: data_o expected %0d, got %0d (slot %s)",
				$time, exp_data, data_o, exp_slot.name());
			total_errors++;
			test_errors++;
		end
		if (!closed && (test_id != cur_test || run_end)) begin
			if (cur_test != 0) begin
				if (test_errors == 0) begin
					n_pass++;
				end else begin
					n_fail++;
				end
				$display("Test %0d: %s, %0d mismatches", cur_test,
					(test_errors == 0) ? "passed" : "failed", test_errors);
			end
			cur_test    = test_id;
			test_errors = 0;
		end
		if (run_end && !closed) begin
			closed = 1'b1;
			$display("Tests passed: %0d, failed: %0d, data mismatches in total: %0d",
				n_pass, n_fail, total_errors);
		end
	end

endmodule

`default_nettype wire
